/* hdl/mipsPkg.sv */
`default_nettype none

package mipsPkg;

	// instruction word, seen as register format or as immediate/jump format
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rView;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} iView;
	} instrWord;

	// primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ANDI  = 6'h0c;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	// function field of OP_RTYPE
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_MFHI = 6'h10;
	localparam logic [5:0] FN_MFLO = 6'h12;
	localparam logic [5:0] FN_MULT = 6'h18;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	// alu operations
	localparam logic [3:0] ALU_ADD  = 4'd0;
	localparam logic [3:0] ALU_SUB  = 4'd1;
	localparam logic [3:0] ALU_AND  = 4'd2;
	localparam logic [3:0] ALU_OR   = 4'd3;
	localparam logic [3:0] ALU_XOR  = 4'd4;
	localparam logic [3:0] ALU_SLT  = 4'd5;
	localparam logic [3:0] ALU_SLL  = 4'd6;
	localparam logic [3:0] ALU_LUI  = 4'd7;
	localparam logic [3:0] ALU_MULT = 4'd8;

	// writeback result select
	localparam logic [1:0] RES_ALU = 2'd0;
	localparam logic [1:0] RES_MEM = 2'd1;
	localparam logic [1:0] RES_HI  = 2'd2;
	localparam logic [1:0] RES_LO  = 2'd3;

	// execute operand forwarding
	localparam logic [1:0] FWD_REG = 2'd0;
	localparam logic [1:0] FWD_WB  = 2'd1;
	localparam logic [1:0] FWD_MEM = 2'd2;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

/* hdl/alu.sv */
`default_nettype none
`timescale 1ns/1ps

module alu import mipsPkg::*; (
	input  wire  [31:0] srcA,
	input  wire  [31:0] srcB,
	input  wire  [4:0]  shamt,
	input  wire  [3:0]  aluOp,
	output logic [31:0] result,
	output logic [63:0] product
);

	always_comb begin
		result = '0;
		product = '0;
		case (aluOp)
			ALU_ADD: result = srcA + srcB;
			ALU_SUB: result = srcA - srcB;
			ALU_AND: result = srcA & srcB;
			ALU_OR:  result = srcA | srcB;
			ALU_XOR: result = srcA ^ srcB;
			ALU_SLT: result = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
			ALU_SLL: result = srcB << shamt;
			// immediate into the upper half
			ALU_LUI: result = {srcB[15:0], 16'h0000};
			// signed 32x32 product, sign extended to 64 bits by context
			ALU_MULT: product = $signed(srcA) * $signed(srcB);
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/controlDecoder.sv */
`default_nettype none
`timescale 1ns/1ps

module controlDecoder import mipsPkg::*; (
	input  wire instrWord instrD,
	output logic [1:0]    resultSelD,
	output logic [3:0]    aluOpD,
	output logic          memWriteD,
	output logic          aluSrcD,
	output logic          regDstD,
	output logic          regWriteD,
	output logic          branchD,
	output logic          branchNeD,
	output logic          jumpD,
	output logic          hiLoWriteD
);

	always_comb begin
		// bubble unless the encoding is recognised
		resultSelD = RES_ALU;
		aluOpD = ALU_ADD;
		memWriteD = 1'b0;
		aluSrcD = 1'b0;
		regDstD = 1'b0;
		regWriteD = 1'b0;
		branchD = 1'b0;
		branchNeD = 1'b0;
		jumpD = 1'b0;
		hiLoWriteD = 1'b0;
		case (instrD.iView.op)
			OP_RTYPE: begin
				regDstD = 1'b1;
				regWriteD = 1'b1;
				case (instrD.rView.funct)
					FN_ADDU: aluOpD = ALU_ADD;
					FN_SUBU: aluOpD = ALU_SUB;
					FN_AND:  aluOpD = ALU_AND;
					FN_OR:   aluOpD = ALU_OR;
					FN_XOR:  aluOpD = ALU_XOR;
					FN_SLT:  aluOpD = ALU_SLT;
					FN_SLL:  aluOpD = ALU_SLL;
					FN_MFHI: resultSelD = RES_HI;
					FN_MFLO: resultSelD = RES_LO;
					FN_MULT: begin
						// product goes to HI/LO only
						aluOpD = ALU_MULT;
						regWriteD = 1'b0;
						hiLoWriteD = 1'b1;
					end
					default: begin
						regDstD = 1'b0;
						regWriteD = 1'b0;
					end
				endcase
			end
			OP_ADDIU: begin
				aluSrcD = 1'b1;
				regWriteD = 1'b1;
			end
			OP_ANDI: begin
				aluOpD = ALU_AND;
				aluSrcD = 1'b1;
				regWriteD = 1'b1;
			end
			OP_ORI: begin
				aluOpD = ALU_OR;
				aluSrcD = 1'b1;
				regWriteD = 1'b1;
			end
			OP_LUI: begin
				aluOpD = ALU_LUI;
				aluSrcD = 1'b1;
				regWriteD = 1'b1;
			end
			OP_LW: begin
				resultSelD = RES_MEM;
				aluSrcD = 1'b1;
				regWriteD = 1'b1;
			end
			OP_SW: begin
				aluSrcD = 1'b1;
				memWriteD = 1'b1;
			end
			OP_BEQ: branchD = 1'b1;
			OP_BNE: begin
				branchD = 1'b1;
				branchNeD = 1'b1;
			end
			OP_J: jumpD = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`default_nettype none
`timescale 1ns/1ps

module regFile (
	input  wire         clk,
	input  wire         rst,
	input  wire         writeEn,
	input  wire  [4:0]  writeAddr,
	input  wire  [31:0] writeData,
	input  wire  [4:0]  readAddrA,
	input  wire  [4:0]  readAddrB,
	output logic [31:0] readDataA,
	output logic [31:0] readDataB
);

	logic [31:0] regs [32];

	// register zero reads as zero, a same-cycle write is passed through
	function automatic logic [31:0] readPort(input logic [4:0] addr);
		if (addr == 5'd0) begin
			return 32'd0;
		end
		if (writeEn && writeAddr == addr) begin
			return writeData;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != 5'd0) begin
			regs[writeAddr] <= writeData;
		end
	end

	always_comb begin
		readDataA = readPort(readAddrA);
		readDataB = readPort(readAddrB);
	end

endmodule

`default_nettype wire

/* hdl/hazardUnit.sv */
`default_nettype none
`timescale 1ns/1ps

module hazardUnit import mipsPkg::*; (
	input  wire  [4:0] rsD,
	input  wire  [4:0] rtD,
	input  wire  [4:0] rsE,
	input  wire  [4:0] rtE,
	input  wire  [4:0] writeRegE,
	input  wire  [4:0] writeRegM,
	input  wire  [4:0] writeRegW,
	input  wire        regWriteE,
	input  wire        regWriteM,
	input  wire        regWriteW,
	input  wire        loadE,
	input  wire        loadM,
	input  wire        branchD,
	output logic       stallF,
	output logic       stallD,
	output logic       flushE,
	output logic       forwardAD,
	output logic       forwardBD,
	output logic [1:0] forwardAE,
	output logic [1:0] forwardBE
);

	logic loadUseStall;
	logic branchStall;

	// memory stage wins over writeback, r0 is never forwarded
	function automatic logic [1:0] execSelect(input logic [4:0] src);
		if (src != 5'd0 && regWriteM && writeRegM == src) begin
			return FWD_MEM;
		end
		if (src != 5'd0 && regWriteW && writeRegW == src) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	// does stage writing dst feed the decode operands
	function automatic logic feedsDecode(input logic [4:0] dst);
		return dst != 5'd0 && (dst == rsD || dst == rtD);
	endfunction

	always_comb begin
		forwardAE = execSelect(rsE);
		forwardBE = execSelect(rtE);
		// branch compare takes memory stage results only
		forwardAD = rsD != 5'd0 && regWriteM && writeRegM == rsD;
		forwardBD = rtD != 5'd0 && regWriteM && writeRegM == rtD;

		loadUseStall = loadE && feedsDecode(writeRegE);
		branchStall = branchD && ((regWriteE && feedsDecode(writeRegE)) ||
			(loadM && feedsDecode(writeRegM)));

		stallF = loadUseStall || branchStall;
		stallD = loadUseStall || branchStall;
		flushE = loadUseStall || branchStall;
	end

endmodule

`default_nettype wire

/* hdl/datapath.sv */
`default_nettype none
`timescale 1ns/1ps

module datapath import mipsPkg::*; (
	input  wire         clk,
	input  wire         rst,
	output logic [31:0] pcF,
	input  wire  [31:0] instrF,
	output logic        memWriteM,
	output logic [31:0] aluOutM,
	output logic [31:0] writeDataM,
	input  wire  [31:0] readDataM,
	output instrWord    instrD,
	input  wire  [1:0]  resultSelD,
	input  wire  [3:0]  aluOpD,
	input  wire         memWriteD,
	input  wire         aluSrcD,
	input  wire         regDstD,
	input  wire         regWriteD,
	input  wire         branchD,
	input  wire         branchNeD,
	input  wire         jumpD,
	input  wire         hiLoWriteD,
	output logic [4:0]  rsD,
	output logic [4:0]  rtD,
	input  wire  [31:0] rsDataD,
	input  wire  [31:0] rtDataD,
	output logic        regWriteW,
	output logic [4:0]  writeRegW,
	output logic [31:0] resultW,
	output logic [4:0]  rsE,
	output logic [4:0]  rtE,
	output logic [4:0]  writeRegE,
	output logic [4:0]  writeRegM,
	output logic        regWriteE,
	output logic        regWriteM,
	output logic        loadE,
	output logic        loadM,
	input  wire         stallF,
	input  wire         stallD,
	input  wire         flushE,
	input  wire         forwardAD,
	input  wire         forwardBD,
	input  wire  [1:0]  forwardAE,
	input  wire  [1:0]  forwardBE
);

	logic [31:0] pcPlus4F, pcNext;
	logic [31:0] pcPlus4D, immD, cmpAD, cmpBD, branchTargetD, jumpTargetD;
	logic        zeroExtD, pcSrcD;
	logic [1:0]  resultSelE;
	logic [3:0]  aluOpE;
	logic        memWriteE, aluSrcE, regDstE, hiLoWriteE;
	logic [31:0] rsDataE, rtDataE, immE, srcAE, srcBE, writeDataE, aluResultE, hiE, loE;
	logic [4:0]  rdE, shamtE;
	logic [63:0] productE;
	logic [1:0]  resultSelM;
	logic        hiLoWriteM;
	logic [31:0] hiM, loM, fwdM;
	logic [63:0] productM;
	logic [1:0]  resultSelW;
	logic        hiLoWriteW;
	logic [31:0] aluOutW, readDataW, hiW, loW, hiReg, loReg;
	logic [63:0] productW;

	// execute operand mux
	function automatic logic [31:0] fwdMux(input logic [1:0] sel, input logic [31:0] regVal);
		case (sel)
			FWD_MEM: return fwdM;
			FWD_WB:  return resultW;
			default: return regVal;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// fetch
	assign pcPlus4F = pcF + 32'd4;
	assign pcNext = jumpD ? jumpTargetD : (pcSrcD ? branchTargetD : pcPlus4F);

	always_ff @(posedge clk) begin
		if (rst) begin
			pcF <= RESET_PC;
		end else if (!stallF) begin
			pcF <= pcNext;
		end
	end

	// decode register, reset loads a nop
	always_ff @(posedge clk) begin
		if (rst) begin
			instrD <= '0;
		end else if (!stallD) begin
			instrD <= instrF;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallD) begin
			pcPlus4D <= pcPlus4F;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// decode, branches resolve here
	assign rsD = instrD.rView.rs;
	assign rtD = instrD.rView.rt;
	// andi and ori take a zero extended immediate
	assign zeroExtD = aluSrcD && (aluOpD == ALU_AND || aluOpD == ALU_OR);
	assign immD = zeroExtD ? {16'h0000, instrD.iView.imm} :
		{{16{instrD.iView.imm[15]}}, instrD.iView.imm};
	assign cmpAD = forwardAD ? fwdM : rsDataD;
	assign cmpBD = forwardBD ? fwdM : rtDataD;
	assign pcSrcD = branchD && ((cmpAD == cmpBD) != branchNeD);
	assign branchTargetD = pcPlus4D + {immD[29:0], 2'b00};
	assign jumpTargetD = {pcPlus4D[31:28], instrD[25:0], 2'b00};

	always_ff @(posedge clk) begin
		if (rst || flushE) begin
			resultSelE <= RES_ALU;
			aluOpE <= ALU_ADD;
			memWriteE <= 1'b0;
			aluSrcE <= 1'b0;
			regDstE <= 1'b0;
			regWriteE <= 1'b0;
			hiLoWriteE <= 1'b0;
		end else begin
			resultSelE <= resultSelD;
			aluOpE <= aluOpD;
			memWriteE <= memWriteD;
			aluSrcE <= aluSrcD;
			regDstE <= regDstD;
			regWriteE <= regWriteD;
			hiLoWriteE <= hiLoWriteD;
		end
	end

	always_ff @(posedge clk) begin
		rsDataE <= rsDataD;
		rtDataE <= rtDataD;
		immE <= immD;
		rsE <= rsD;
		rtE <= rtD;
		rdE <= instrD.rView.rd;
		shamtE <= instrD.rView.shamt;
	end

	////////////////////////////////////////////////////////////////////////////
	// execute
	always_comb begin
		srcAE = fwdMux(forwardAE, rsDataE);
		writeDataE = fwdMux(forwardBE, rtDataE);
		srcBE = aluSrcE ? immE : writeDataE;
		writeRegE = regDstE ? rdE : rtE;
		loadE = resultSelE == RES_MEM;
		// HI/LO as seen by this instruction, newest mult first
		if (hiLoWriteM) begin
			{hiE, loE} = productM;
		end else if (hiLoWriteW) begin
			{hiE, loE} = productW;
		end else begin
			{hiE, loE} = {hiReg, loReg};
		end
	end

	alu u_alu (
		.srcA(srcAE),
		.srcB(srcBE),
		.shamt(shamtE),
		.aluOp(aluOpE),
		.result(aluResultE),
		.product(productE)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			resultSelM <= RES_ALU;
			memWriteM <= 1'b0;
			regWriteM <= 1'b0;
			hiLoWriteM <= 1'b0;
		end else begin
			resultSelM <= resultSelE;
			memWriteM <= memWriteE;
			regWriteM <= regWriteE;
			hiLoWriteM <= hiLoWriteE;
		end
	end

	always_ff @(posedge clk) begin
		aluOutM <= aluResultE;
		writeDataM <= writeDataE;
		writeRegM <= writeRegE;
		productM <= productE;
		hiM <= hiE;
		loM <= loE;
	end

	////////////////////////////////////////////////////////////////////////////
	// memory, value offered for forwarding
	assign loadM = resultSelM == RES_MEM;
	assign fwdM = (resultSelM == RES_HI) ? hiM : ((resultSelM == RES_LO) ? loM : aluOutM);

	always_ff @(posedge clk) begin
		if (rst) begin
			resultSelW <= RES_ALU;
			regWriteW <= 1'b0;
			hiLoWriteW <= 1'b0;
		end else begin
			resultSelW <= resultSelM;
			regWriteW <= regWriteM;
			hiLoWriteW <= hiLoWriteM;
		end
	end

	always_ff @(posedge clk) begin
		aluOutW <= aluOutM;
		readDataW <= readDataM;
		writeRegW <= writeRegM;
		productW <= productM;
		hiW <= hiM;
		loW <= loM;
	end

	// writeback
	always_comb begin
		case (resultSelW)
			RES_MEM: resultW = readDataW;
			RES_HI:  resultW = hiW;
			RES_LO:  resultW = loW;
			default: resultW = aluOutW;
		endcase
	end

	// HI/LO commit at the end of writeback
	always_ff @(posedge clk) begin
		if (rst) begin
			hiReg <= '0;
			loReg <= '0;
		end else if (hiLoWriteW) begin
			{hiReg, loReg} <= productW;
		end
	end

endmodule

`default_nettype wire

/* hdl/mipsCore.sv */
`default_nettype none
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; (
	input  wire         clk,
	input  wire         rst,
	output logic [31:0] pcF,
	input  wire  [31:0] instrF,
	output logic        memWriteM,
	output logic [31:0] aluOutM,
	output logic [31:0] writeDataM,
	input  wire  [31:0] readDataM
);

	// decode stage controls
	instrWord    instrD;
	logic [1:0]  resultSelD;
	logic [3:0]  aluOpD;
	logic        memWriteD, aluSrcD, regDstD, regWriteD;
	logic        branchD, branchNeD, jumpD, hiLoWriteD;

	// register file
	logic [4:0]  rsD, rtD, writeRegW;
	logic [31:0] rsDataD, rtDataD, resultW;
	logic        regWriteW;

	// hazards
	logic [4:0]  rsE, rtE, writeRegE, writeRegM;
	logic        regWriteE, regWriteM, loadE, loadM;
	logic        stallF, stallD, flushE, forwardAD, forwardBD;
	logic [1:0]  forwardAE, forwardBE;

	controlDecoder u_controlDecoder (.*);

	datapath u_datapath (.*);

	hazardUnit u_hazardUnit (.*);

	regFile u_regFile (
		.clk(clk),
		.rst(rst),
		.writeEn(regWriteW),
		.writeAddr(writeRegW),
		.writeData(resultW),
		.readAddrA(rsD),
		.readAddrB(rtD),
		.readDataA(rsDataD),
		.readDataB(rtDataD)
	);

endmodule

`default_nettype wire

/* dv/tbClock.sv */
`default_nettype none
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic rst
);

	// 8 ns period, reset held from time zero
	initial begin
		clk = 1'b0;
		rst = 1'b1;
		forever begin
			#4 clk = ~clk;
		end
	end

	// reset rises on a falling edge and stays up until endReset
	task automatic startReset();
		@(negedge clk);
		rst = 1'b1;
	endtask

	// ten cycles of reset in all, released on a falling edge
	task automatic endReset();
		repeat (10) @(negedge clk);
		rst = 1'b0;
	endtask

endmodule

`default_nettype wire

/* dv/tbChecker.sv */
`default_nettype none
`timescale 1ns/1ps

module tbChecker import mipsPkg::*; (
	input wire        clk,
	input wire        rst,
	input wire [31:0] pcF,
	input wire        memWriteM,
	input wire [31:0] aluOutM,
	input wire [31:0] writeDataM
);

	localparam int PROG_WORDS = 1024;
	localparam int DATA_WORDS = 128;
	localparam int MAX_STEPS = 4096;

	logic [31:0] prog [PROG_WORDS];
	logic [31:0] mem [DATA_WORDS];
	// expected stores in order, address in the upper word
	logic [63:0] expStores [$];
	string       testName;
	bit          active;
	int unsigned seen;
	int unsigned errors;

	initial begin
		active = 1'b0;
		seen = 0;
		errors = 0;
	end

	task automatic setInstr(input int unsigned idx, input logic [31:0] word);
		prog[idx] = word;
	endtask

	task automatic setData(input int unsigned idx, input logic [31:0] word);
		mem[idx] = word;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model, runs the whole program ahead of the DUT
	task automatic predict(input string name, input int unsigned loopIdx);
		logic [31:0] regs [32];
		logic [31:0] pc, npc, target, a, b, simm, zimm, addr, hi, lo;
		logic [63:0] prod;
		instrWord    w;
		int unsigned steps;
		testName = name;
		active = 1'b1;
		seen = 0;
		errors = 0;
		expStores.delete();
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		hi = '0;
		lo = '0;
		pc = RESET_PC;
		npc = RESET_PC + 32'd4;
		steps = 0;
		while (pc != 32'(loopIdx * 4) && steps < MAX_STEPS) begin
			w = prog[pc[11:2]];
			a = regs[w.rView.rs];
			b = regs[w.rView.rt];
			simm = {{16{w.iView.imm[15]}}, w.iView.imm};
			zimm = {16'h0000, w.iView.imm};
			// sequential unless a branch or jump redirects after its delay slot
			target = npc + 32'd4;
			case (w.iView.op)
				OP_RTYPE: begin
					case (w.rView.funct)
						FN_ADDU: regs[w.rView.rd] = a + b;
						FN_SUBU: regs[w.rView.rd] = a - b;
						FN_AND:  regs[w.rView.rd] = a & b;
						FN_OR:   regs[w.rView.rd] = a | b;
						FN_XOR:  regs[w.rView.rd] = a ^ b;
						FN_SLT:  regs[w.rView.rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						FN_SLL:  regs[w.rView.rd] = b << w.rView.shamt;
						FN_MFHI: regs[w.rView.rd] = hi;
						FN_MFLO: regs[w.rView.rd] = lo;
						FN_MULT: begin
							// low 64 bits of the sign extended operands
							prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
							hi = prod[63:32];
							lo = prod[31:0];
						end
						default: ;
					endcase
				end
				OP_ADDIU: regs[w.iView.rt] = a + simm;
				OP_ANDI:  regs[w.iView.rt] = a & zimm;
				OP_ORI:   regs[w.iView.rt] = a | zimm;
				OP_LUI:   regs[w.iView.rt] = {w.iView.imm, 16'h0000};
				OP_LW: begin
					addr = a + simm;
					regs[w.iView.rt] = mem[addr[8:2]];
				end
				OP_SW: begin
					addr = a + simm;
					expStores.push_back({addr, b});
					mem[addr[8:2]] = b;
				end
				OP_BEQ: begin
					if (a == b) begin
						target = npc + {simm[29:0], 2'b00};
					end
				end
				OP_BNE: begin
					if (a != b) begin
						target = npc + {simm[29:0], 2'b00};
					end
				end
				OP_J: target = {npc[31:28], w[25:0], 2'b00};
				default: ;
			endcase
			regs[0] = '0;
			pc = npc;
			npc = target;
			steps++;
		end
		if (steps >= MAX_STEPS) begin
			$display("%s: the model never reached the final loop", name);
			errors++;
		end
	endtask

	// state right after reset release, before any instruction
	task automatic checkReset();
		if (pcF !== RESET_PC) begin
			$display("FAIL %s reset pcF: expected %h, actual %h", testName, RESET_PC, pcF);
			errors++;
		end
		if (memWriteM !== 1'b0) begin
			$display("FAIL %s reset memWriteM: expected 0, actual %b", testName, memWriteM);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// store compare, each cycle with memWriteM high is one store
	always @(negedge clk) begin
		if (active && !rst && memWriteM === 1'b1) begin
			if (seen < expStores.size()) begin
				if ({aluOutM, writeDataM} !== expStores[seen]) begin
					$display("FAIL %s store %0d: expected addr %h data %h, actual addr %h data %h",
						testName, seen, expStores[seen][63:32], expStores[seen][31:0],
						aluOutM, writeDataM);
					errors++;
				end
			end
			seen++;
		end
	end

	task automatic endTest(output int unsigned errs);
		if (seen != expStores.size()) begin
			$display("%s: the DUT made %0d stores but the model expects %0d",
				testName, seen, expStores.size());
			errors++;
		end
		active = 1'b0;
		errs = errors;
	endtask

endmodule

`default_nettype wire

/* dv/tbMips.sv */
`default_nettype none
`timescale 1ns/1ps

module tbMips import mipsPkg::*; ();

	localparam int PROG_WORDS = 1024;
	localparam int DATA_WORDS = 128;
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int MIX_ALU = 0;
	localparam int MIX_MEM = 1;
	localparam int MIX_BRANCH = 2;
	localparam int MIX_MULT = 3;
	localparam int MIX_ALL = 4;

	logic        clk, rst;
	logic [31:0] pcF, instrF, aluOutM, writeDataM, readDataM;
	logic        memWriteM;

	logic [31:0] progMem [PROG_WORDS];
	logic [31:0] dataMem [DATA_WORDS];
	int unsigned progLen, loopIdx, passCount, failCount;
	logic [4:0]  lastDest;

	tbClock u_clock (
		.clk(clk),
		.rst(rst)
	);

	mipsCore u_mipsCore (
		.clk(clk),
		.rst(rst),
		.pcF(pcF),
		.instrF(instrF),
		.memWriteM(memWriteM),
		.aluOutM(aluOutM),
		.writeDataM(writeDataM),
		.readDataM(readDataM)
	);

	tbChecker u_checker (
		.clk(clk),
		.rst(rst),
		.pcF(pcF),
		.memWriteM(memWriteM),
		.aluOutM(aluOutM),
		.writeDataM(writeDataM)
	);

	// both memories word indexed, reads are combinational
	assign instrF = progMem[pcF[11:2]];
	assign readDataM = dataMem[aluOutM[8:2]];

	always @(posedge clk) begin
		if (memWriteM === 1'b1) begin
			dataMem[aluOutM[8:2]] <= writeDataM;
		end
	end

	function automatic logic [31:0] fillWord(input int unsigned idx);
		logic [31:0] addr;
		addr = 32'(idx * 4);
		return {~addr[15:0], addr[15:0]} ^ (addr * 32'h9e37_79b9);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// instruction encoding
	function automatic logic [31:0] rInstr(input logic [5:0] funct, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		instrWord w;
		w.rView.op = OP_RTYPE;
		w.rView.rs = rs;
		w.rView.rt = rt;
		w.rView.rd = rd;
		w.rView.shamt = shamt;
		w.rView.funct = funct;
		return w;
	endfunction

	function automatic logic [31:0] iInstr(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		instrWord w;
		w.iView.op = op;
		w.iView.rs = rs;
		w.iView.rt = rt;
		w.iView.imm = imm;
		return w;
	endfunction

	function automatic logic [31:0] jInstr(input int unsigned idx);
		return {OP_J, 26'(idx)};
	endfunction

	task automatic emit(input logic [31:0] word);
		progMem[progLen] = word;
		progLen++;
	endtask

	// mostly a few low registers, so dependencies stay dense
	function automatic logic [4:0] pickReg();
		if ($urandom % 4 != 0) begin
			return 5'($urandom % 7 + 1);
		end
		return 5'($urandom % 32);
	endfunction

	function automatic logic [4:0] pickSrc();
		if ($urandom % 2 == 0) begin
			return lastDest;
		end
		return pickReg();
	endfunction

	task automatic emitAlu();
		logic [4:0]  rs, rt, rd;
		logic [15:0] imm;
		rs = pickSrc();
		rt = pickSrc();
		rd = pickReg();
		imm = 16'($urandom);
		case ($urandom % 11)
			0: emit(rInstr(FN_ADDU, rs, rt, rd, 5'd0));
			1: emit(rInstr(FN_SUBU, rs, rt, rd, 5'd0));
			2: emit(rInstr(FN_AND, rs, rt, rd, 5'd0));
			3: emit(rInstr(FN_OR, rs, rt, rd, 5'd0));
			4: emit(rInstr(FN_XOR, rs, rt, rd, 5'd0));
			5: emit(rInstr(FN_SLT, rs, rt, rd, 5'd0));
			6: emit(rInstr(FN_SLL, 5'd0, rt, rd, 5'($urandom)));
			7: emit(iInstr(OP_ADDIU, rs, rd, imm));
			8: emit(iInstr(OP_ANDI, rs, rd, imm));
			9: emit(iInstr(OP_ORI, rs, rd, imm));
			default: emit(iInstr(OP_LUI, 5'd0, rd, imm));
		endcase
		lastDest = rd;
	endtask

	// loads and stores stay in the first 16 words
	task automatic emitMem();
		logic [4:0]  rt;
		logic [15:0] offset;
		offset = 16'(4 * ($urandom % 16));
		if ($urandom % 2 == 0) begin
			rt = pickReg();
			emit(iInstr(OP_LW, 5'd0, rt, offset));
			lastDest = rt;
		end else begin
			emit(iInstr(OP_SW, 5'd0, pickSrc(), offset));
		end
	endtask

	task automatic emitMult();
		logic [4:0] rd;
		emit(rInstr(FN_MULT, pickSrc(), pickSrc(), 5'd0, 5'd0));
		if ($urandom % 2 == 0) begin
			rd = pickReg();
			emit(rInstr(FN_MFHI, 5'd0, 5'd0, rd, 5'd0));
			lastDest = rd;
		end
		if ($urandom % 2 == 0) begin
			rd = pickReg();
			emit(rInstr(FN_MFLO, 5'd0, 5'd0, rd, 5'd0));
			lastDest = rd;
		end
	endtask

	// forward only, target lands 1 to 4 words past the delay slot
	task automatic emitBranch();
		logic [4:0]  rs, rt;
		int unsigned skip, here;
		skip = $urandom % 4 + 1;
		here = progLen;
		rs = lastDest;
		rt = ($urandom % 2 == 0) ? rs : pickReg();
		case ($urandom % 3)
			0: emit(iInstr(OP_BEQ, rs, rt, 16'(skip)));
			1: emit(iInstr(OP_BNE, rs, rt, 16'(skip)));
			default: emit(jInstr(here + 1 + skip));
		endcase
		emitAlu();
	endtask

	task automatic buildProgram(input int mix, input int unsigned len);
		int unsigned brPct, memPct, mulPct, r;
		brPct = 0;
		memPct = 0;
		mulPct = 0;
		case (mix)
			MIX_MEM: memPct = 50;
			MIX_BRANCH: brPct = 30;
			MIX_MULT: mulPct = 35;
			MIX_ALL: begin
				brPct = 15;
				memPct = 25;
				mulPct = 15;
			end
			default: ;
		endcase
		for (int i = 0; i < PROG_WORDS; i++) begin
			progMem[i] = '0;
		end
		progLen = 0;
		lastDest = pickReg();
		while (progLen < len) begin
			r = $urandom % 100;
			if (r < brPct && progLen + 6 <= len) begin
				emitBranch();
			end else if (r < brPct + memPct) begin
				emitMem();
			end else if (r < brPct + memPct + mulPct) begin
				emitMult();
			end else begin
				emitAlu();
			end
		end
		// tail dumps every register and HI/LO to the result area
		for (int i = 1; i < 32; i++) begin
			emit(iInstr(OP_SW, 5'd0, 5'(i), 16'(32'h100 + 4 * i)));
		end
		emit(rInstr(FN_MFHI, 5'd0, 5'd0, 5'd1, 5'd0));
		emit(iInstr(OP_SW, 5'd0, 5'd1, 16'h0180));
		emit(rInstr(FN_MFLO, 5'd0, 5'd0, 5'd1, 5'd0));
		emit(iInstr(OP_SW, 5'd0, 5'd1, 16'h0184));
		loopIdx = progLen;
		emit(jInstr(loopIdx));
		emit(32'h0000_0000);
	endtask

	////////////////////////////////////////////////////////////////////////////
	task automatic runTest(input string name, input int mix, input int unsigned len);
		int unsigned errs, visits, cycles;
		u_clock.startReset();
		buildProgram(mix, len);
		for (int i = 0; i < PROG_WORDS; i++) begin
			u_checker.setInstr(i, progMem[i]);
		end
		for (int i = 0; i < DATA_WORDS; i++) begin
			dataMem[i] = fillWord(i);
			u_checker.setData(i, dataMem[i]);
		end
		u_checker.predict(name, loopIdx);
		u_clock.endReset();
		u_checker.checkReset();
		// the self loop alternates with its delay slot, several visits drain the pipe
		visits = 0;
		cycles = 0;
		while (visits < 4 && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
			if (pcF == 32'(loopIdx * 4)) begin
				visits++;
			end
		end
		u_checker.endTest(errs);
		if (visits < 4) begin
			$display("%s: the program never finished within %0d cycles", name, TIMEOUT_CYCLES);
			errs++;
		end
		if (errs == 0) begin
			passCount++;
			$display("%s: passed", name);
		end else begin
			failCount++;
			$display("%s: failed with %0d errors", name, errs);
		end
	endtask

	initial begin
		void'($urandom(32'hfd6e));
		passCount = 0;
		failCount = 0;
		for (int i = 0; i < PROG_WORDS; i++) begin
			progMem[i] = '0;
		end
		for (int i = 0; i < DATA_WORDS; i++) begin
			dataMem[i] = fillWord(i);
		end
		runTest("aluChains", MIX_ALU, 150);
		runTest("loadStore", MIX_MEM, 150);
		runTest("branches", MIX_BRANCH, 200);
		runTest("multHiLo", MIX_MULT, 120);
		runTest("mixedA", MIX_ALL, 400);
		runTest("mixedB", MIX_ALL, 400);
		$display("tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hdl/mipsPkg.sv
hdl/alu.sv
hdl/controlDecoder.sv
hdl/regFile.sv
hdl/hazardUnit.sv
hdl/datapath.sv
hdl/mipsCore.sv
dv/tbClock.sv
dv/tbChecker.sv
dv/tbMips.sv

/* Bender.yml */
package:
  name: mipsCore

sources:
  - hdl/mipsPkg.sv
  - hdl/alu.sv
  - hdl/controlDecoder.sv
  - hdl/regFile.sv
  - hdl/hazardUnit.sv
  - hdl/datapath.sv
  - hdl/mipsCore.sv
  - target: simulation
    files:
      - dv/tbClock.sv
      - dv/tbChecker.sv
      - dv/tbMips.sv
